/* dv/predictor_testdata.txt */
# tag en fpc1 fv1 fpc2 fv2 bpc1 bres1 bv1 bpc2 bres2 bv2
# then expected next cycle: valid1 taken1 strong1 valid2 taken2 strong2
reset 1 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
reset 1 10 1 24 1 0 0 0 0 0 0 1 0 1 1 0 1
train 1 10 1 0 0 10 1 1 0 0 0 1 0 1 0 0 0
train 1 10 1 0 0 10 1 1 0 0 0 1 0 1 0 0 0
train 1 10 1 0 0 10 1 1 0 0 0 1 0 1 0 0 0
train 1 10 1 0 0 10 1 1 0 0 0 1 0 1 0 0 0
train 1 10 1 0 0 10 1 1 0 0 0 1 0 0 0 0 0
train 1 10 1 0 0 10 1 1 0 0 0 1 1 0 0 0 0
train 1 10 1 0 0 10 1 1 0 0 0 1 1 1 0 0 0
train 1 10 1 0 0 0 0 0 0 0 0 1 1 1 0 0 0
untrain 1 10 1 0 0 10 0 1 0 0 0 1 1 1 0 0 0
untrain 1 10 1 0 0 10 0 1 0 0 0 1 0 1 0 0 0
untrain 1 10 1 0 0 10 0 1 0 0 0 1 0 1 0 0 0
untrain 1 10 1 0 0 10 0 1 0 0 0 1 0 0 0 0 0
untrain 1 10 1 0 0 0 0 0 0 0 0 1 0 1 0 0 0
chain 1 0 0 0 0 24 1 1 24 1 1 0 0 0 0 0 0
chain 1 24 1 10 1 0 0 0 0 0 0 1 0 0 1 0 0
chain 1 10 1 0 0 10 1 1 08 1 1 1 0 0 0 0 0
chain 1 08 1 00 1 0 0 0 0 0 0 1 1 0 1 1 1
separate 1 10 1 24 1 10 0 1 24 1 1 1 1 0 1 0 0
separate 1 10 1 24 1 0 0 0 0 0 0 1 0 1 1 1 0
gate 0 10 1 24 1 24 1 1 0 0 0 0 0 0 0 0 0
gate 0 24 1 0 0 24 1 1 0 0 0 0 0 0 0 0 0
gate 1 24 1 10 1 0 0 0 0 0 0 1 1 1 1 0 1

/* local_predictor_top.f */
hw/bp_pkg.sv
hw/resolve_update_unit.sv
hw/local_history_table.sv
hw/pattern_counter_table.sv
hw/prediction_output.sv
hw/local_predictor_top.sv
dv/predictor_checker.sv
dv/local_predictor_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f local_predictor_top.f \
	--top-module local_predictor_tb -o sim_local_predictor > build.log 2>&1 \
	&& ./obj_dir/sim_local_predictor > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "SOME TESTS FAILED" sim.log \
	&& { echo "simulation reported failures, see sim.log"; exit 1; } \
	|| { echo "simulation clean"; exit 0; }

/* dv/local_predictor_tb.sv */
`timescale 1ns/1ps

module local_predictor_tb;

	localparam int max_cycles = 200;

	logic clock;
	logic reset;
	logic predict_enable;
	logic [63:0] fetch_pc1, fetch_pc2, branch_pc1, branch_pc2;
	logic fetch_valid1, fetch_valid2;
	logic branch_result1, branch_valid1, branch_result2, branch_valid2;
	logic predict_valid1, predict_taken1, predict_strong1;
	logic predict_valid2, predict_taken2, predict_strong2;

	logic [5:0] expected; // {valid1, taken1, strong1, valid2, taken2, strong2}
	logic [8*16-1:0] test_tag;
	logic check_en;
	logic done;
	int test_count, failed_count, error_count;

	int fd, fields, cycles;
	string line;
	logic [63:0] f_pc1, f_pc2, b_pc1, b_pc2;
	logic en, fv1, fv2, br1, bv1, br2, bv2;
	logic ev1, et1, es1, ev2, et2, es2;

	local_predictor_top uut (.*);

	predictor_checker u_checker (
		.clock, .check_en, .test_tag, .expected, .done,
		.predict_valid1, .predict_taken1, .predict_strong1,
		.predict_valid2, .predict_taken2, .predict_strong2,
		.test_count, .failed_count, .error_count
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		// valid fetches during reset must predict nothing
		predict_enable = 1'b1;
		{fetch_pc1, fetch_pc2} = '0;
		{fetch_valid1, fetch_valid2} = 2'b11;
		{branch_pc1, branch_result1, branch_valid1} = '0;
		{branch_pc2, branch_result2, branch_valid2} = '0;
		expected = '0;
		test_tag = "after_reset";
		check_en = 1'b1;
		done = 1'b0;
		cycles = 0;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		{fetch_valid1, fetch_valid2} = '0;
		check_en = 1'b0;

		fd = $fopen("dv/predictor_testdata.txt", "r");
		if (fd == 0)
			$display("could not open the test vector file");

		// one vector per cycle and comment lines skipped
		while (fd != 0 && !$feof(fd) && cycles < max_cycles) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line[0] == "#")
				continue;
			fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				test_tag, en, f_pc1, fv1, f_pc2, fv2, b_pc1, br1, bv1, b_pc2, br2, bv2,
				ev1, et1, es1, ev2, et2, es2);
			if (fields != 18)
				continue;
			@(posedge clock);
			#1;
			predict_enable = en;
			fetch_pc1 = f_pc1;
			fetch_valid1 = fv1;
			fetch_pc2 = f_pc2;
			fetch_valid2 = fv2;
			{branch_pc1, branch_result1, branch_valid1} = {b_pc1, br1, bv1};
			{branch_pc2, branch_result2, branch_valid2} = {b_pc2, br2, bv2};
			expected = {ev1, et1, es1, ev2, et2, es2};
			check_en = 1'b1;
			cycles++;
		end

		if (fd == 0) begin
			$display("SOME TESTS FAILED");
		end else if (cycles >= max_cycles) begin
			$fclose(fd);
			$display("timeout: stimulus did not finish within %0d cycles", max_cycles);
			$display("SOME TESTS FAILED");
		end else begin
			$fclose(fd);
			// let the last vector's prediction come out and be compared
			@(posedge clock);
			#1;
			{fetch_valid1, fetch_valid2, branch_valid1, branch_valid2} = '0;
			check_en = 1'b0;
			@(posedge clock);
			#1 done = 1'b1;
			#1;
			$display("tests run: %0d, tests failed: %0d, checks failed: %0d",
				test_count, failed_count, error_count);
			if (failed_count == 0 && test_count > 0) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
		end
		$finish;
	end

endmodule

/* dv/predictor_checker.sv */
`timescale 1ns/1ps

module predictor_checker (
	input  logic            clock,
	input  logic            check_en,
	input  logic [8*16-1:0] test_tag,
	input  logic [5:0]      expected,
	input  logic            done,
	input  logic            predict_valid1,
	input  logic            predict_taken1,
	input  logic            predict_strong1,
	input  logic            predict_valid2,
	input  logic            predict_taken2,
	input  logic            predict_strong2,
	output int              test_count,
	output int              failed_count,
	output int              error_count
);

	logic            pending = 1'b0;
	logic [8*16-1:0] cap_tag;
	logic [5:0]      cap_expected;
	logic [8*16-1:0] cur_tag = '0;
	int              cur_errors = 0;
	logic [5:0]      actual;

	initial begin
		test_count = 0;
		failed_count = 0;
		error_count = 0;
	end

	task automatic close_test();
		if (cur_tag != '0) begin
			test_count++;
			if (cur_errors != 0) failed_count++;
			$display("test %0s: %s (%0d mismatches)", cur_tag,
				cur_errors == 0 ? "passed" : "failed", cur_errors);
		end
	endtask

	// expected values latched at the edge that registers the prediction
	always @(posedge clock) begin
		pending <= check_en;
		cap_tag <= test_tag;
		cap_expected <= expected;
	end

	// ==================================================
	// compare at the falling edge once outputs settle
	// ==================================================
	always @(negedge clock or posedge done) begin
		if (done) begin
			close_test(); // flush last tag
			cur_tag = '0;
		end else if (pending) begin
			if (cap_tag != cur_tag) begin
				close_test();
				cur_tag = cap_tag;
				cur_errors = 0;
			end
			actual = {predict_valid1, predict_taken1, predict_strong1,
				predict_valid2, predict_taken2, predict_strong2};
			if (actual !== cap_expected) begin
				$display("CHECK FAILED test %0s expected %b actual %b",
					cur_tag, cap_expected, actual);
				cur_errors++;
				error_count++;
			end
		end
	end

endmodule

/* hw/local_predictor_top.sv */
`timescale 1ns/1ps

module local_predictor_top #(
	parameter int index_bits   = 4,
	parameter int history_bits = 3
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        predict_enable,
	input  logic [bp_pkg::PC_WIDTH-1:0] fetch_pc1,
	input  logic                        fetch_valid1,
	input  logic [bp_pkg::PC_WIDTH-1:0] fetch_pc2,
	input  logic                        fetch_valid2,
	input  logic [bp_pkg::PC_WIDTH-1:0] branch_pc1,
	input  logic                        branch_result1,
	input  logic                        branch_valid1,
	input  logic [bp_pkg::PC_WIDTH-1:0] branch_pc2,
	input  logic                        branch_result2,
	input  logic                        branch_valid2,
	output logic                        predict_valid1,
	output logic                        predict_taken1,
	output logic                        predict_strong1,
	output logic                        predict_valid2,
	output logic                        predict_taken2,
	output logic                        predict_strong2
);

	logic [index_bits-1:0]   hist_rd_index1, hist_rd_index2;
	logic [history_bits-1:0] hist_rd1, hist_rd2;
	logic                    hist_wr_en1, hist_wr_en2;
	logic [index_bits-1:0]   hist_wr_index1, hist_wr_index2;
	logic [history_bits-1:0] hist_wr_data1, hist_wr_data2;
	logic                    cnt_upd_en1, cnt_upd_en2;
	logic [history_bits-1:0] cnt_upd_index1, cnt_upd_index2;
	logic                    cnt_upd_taken1, cnt_upd_taken2;
	logic [history_bits-1:0] fetch_hist1, fetch_hist2;
	bp_pkg::counter_state_t  fetch_state1, fetch_state2;

	// ==================================================
	// resolution side
	// ==================================================
	resolve_update_unit #(
		.index_bits(index_bits),
		.history_bits(history_bits)
	) u_resolve (
		.branch_pc1, .branch_result1, .branch_valid1,
		.branch_pc2, .branch_result2, .branch_valid2,
		.hist_rd1, .hist_rd2,
		.hist_rd_index1, .hist_rd_index2,
		.hist_wr_en1, .hist_wr_en2,
		.hist_wr_index1, .hist_wr_index2,
		.hist_wr_data1, .hist_wr_data2,
		.cnt_upd_en1, .cnt_upd_en2,
		.cnt_upd_index1, .cnt_upd_index2,
		.cnt_upd_taken1, .cnt_upd_taken2
	);

	// ==================================================
	// tables
	// ==================================================
	local_history_table #(
		.index_bits(index_bits),
		.history_bits(history_bits)
	) u_history (
		.clock, .reset,
		.fetch_pc1, .fetch_pc2,
		.hist_rd_index1, .hist_rd_index2,
		.hist_wr_en1, .hist_wr_en2,
		.hist_wr_index1, .hist_wr_index2,
		.hist_wr_data1, .hist_wr_data2,
		.fetch_hist1, .fetch_hist2,
		.hist_rd1, .hist_rd2
	);

	pattern_counter_table #(
		.history_bits(history_bits)
	) u_counters (
		.clock, .reset,
		.fetch_hist1, .fetch_hist2,
		.cnt_upd_en1, .cnt_upd_en2,
		.cnt_upd_index1, .cnt_upd_index2,
		.cnt_upd_taken1, .cnt_upd_taken2,
		.fetch_state1, .fetch_state2
	);

	prediction_output u_output ( // one cycle fetch to prediction
		.clock, .reset, .predict_enable,
		.fetch_valid1, .fetch_valid2,
		.fetch_state1, .fetch_state2,
		.predict_valid1, .predict_valid2,
		.predict_taken1, .predict_taken2,
		.predict_strong1, .predict_strong2
	);

endmodule

/* hw/prediction_output.sv */
`timescale 1ns/1ps

module prediction_output (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   predict_enable,
	input  logic                   fetch_valid1,
	input  logic                   fetch_valid2,
	input  bp_pkg::counter_state_t fetch_state1,
	input  bp_pkg::counter_state_t fetch_state2,
	output logic                   predict_valid1,
	output logic                   predict_valid2,
	output logic                   predict_taken1,
	output logic                   predict_taken2,
	output logic                   predict_strong1,
	output logic                   predict_strong2
);

	logic valid1;
	logic valid2;

	assign valid1 = fetch_valid1 && predict_enable;
	assign valid2 = fetch_valid2 && predict_enable;

	always_ff @(posedge clock) begin
		if (reset) begin
			predict_valid1  <= 1'b0;
			predict_valid2  <= 1'b0;
			predict_taken1  <= 1'b0;
			predict_taken2  <= 1'b0;
			predict_strong1 <= 1'b0;
			predict_strong2 <= 1'b0;
		end else begin
			predict_valid1  <= valid1;
			predict_valid2  <= valid2;
			// taken for the upper half, strong for the outer pair
			predict_taken1  <= valid1 && fetch_state1[1];
			predict_taken2  <= valid2 && fetch_state2[1];
			predict_strong1 <= valid1 && (fetch_state1[1] == fetch_state1[0]);
			predict_strong2 <= valid2 && (fetch_state2[1] == fetch_state2[0]);
		end
	end

endmodule

/* hw/pattern_counter_table.sv */
`timescale 1ns/1ps

module pattern_counter_table #(
	parameter int history_bits = 3
) (
	input  logic                    clock,
	input  logic                    reset,
	input  logic [history_bits-1:0] fetch_hist1,
	input  logic [history_bits-1:0] fetch_hist2,
	input  logic                    cnt_upd_en1,
	input  logic                    cnt_upd_en2,
	input  logic [history_bits-1:0] cnt_upd_index1,
	input  logic [history_bits-1:0] cnt_upd_index2,
	input  logic                    cnt_upd_taken1,
	input  logic                    cnt_upd_taken2,
	output bp_pkg::counter_state_t  fetch_state1,
	output bp_pkg::counter_state_t  fetch_state2
);

	localparam int counters = 2 ** history_bits;

	bp_pkg::counter_state_t cnt_mem [counters];
	bp_pkg::counter_state_t next_state1;
	bp_pkg::counter_state_t base_state2;
	bp_pkg::counter_state_t next_state2;

	// one step toward the outcome and held at both ends
	function automatic bp_pkg::counter_state_t sat_step(
		input bp_pkg::counter_state_t state,
		input logic                   taken
	);
		bp_pkg::counter_state_t result;
		case (state)
			bp_pkg::strong_not_taken:
				result = taken ? bp_pkg::weak_not_taken : bp_pkg::strong_not_taken;
			bp_pkg::weak_not_taken:
				result = taken ? bp_pkg::weak_taken : bp_pkg::strong_not_taken;
			bp_pkg::weak_taken:
				result = taken ? bp_pkg::strong_taken : bp_pkg::weak_not_taken;
			default:
				result = taken ? bp_pkg::strong_taken : bp_pkg::weak_taken;
		endcase
		return result;
	endfunction

	// ==================================================
	// ordered updates
	// ==================================================
	assign next_state1 = sat_step(cnt_mem[cnt_upd_index1], cnt_upd_taken1);

	// update 2 stacks on update 1 when both hit one counter
	assign base_state2 = (cnt_upd_en1 && (cnt_upd_index1 == cnt_upd_index2)) ?
		next_state1 : cnt_mem[cnt_upd_index2];
	assign next_state2 = sat_step(base_state2, cnt_upd_taken2);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < counters; i++) begin
				cnt_mem[i] <= bp_pkg::strong_not_taken;
			end
		end else begin
			if (cnt_upd_en1)
				cnt_mem[cnt_upd_index1] <= next_state1;
			if (cnt_upd_en2)
				cnt_mem[cnt_upd_index2] <= next_state2;
		end
	end

	assign fetch_state1 = cnt_mem[fetch_hist1];
	assign fetch_state2 = cnt_mem[fetch_hist2];

endmodule

/* hw/local_history_table.sv */
`timescale 1ns/1ps

module local_history_table #(
	parameter int index_bits   = 4,
	parameter int history_bits = 3
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic [bp_pkg::PC_WIDTH-1:0] fetch_pc1,
	input  logic [bp_pkg::PC_WIDTH-1:0] fetch_pc2,
	input  logic [index_bits-1:0]       hist_rd_index1,
	input  logic [index_bits-1:0]       hist_rd_index2,
	input  logic                        hist_wr_en1,
	input  logic                        hist_wr_en2,
	input  logic [index_bits-1:0]       hist_wr_index1,
	input  logic [index_bits-1:0]       hist_wr_index2,
	input  logic [history_bits-1:0]     hist_wr_data1,
	input  logic [history_bits-1:0]     hist_wr_data2,
	output logic [history_bits-1:0]     fetch_hist1,
	output logic [history_bits-1:0]     fetch_hist2,
	output logic [history_bits-1:0]     hist_rd1,
	output logic [history_bits-1:0]     hist_rd2
);

	localparam int entries = 2 ** index_bits;

	logic [history_bits-1:0] hist_mem [entries];
	logic [index_bits-1:0]   fetch_index1;
	logic [index_bits-1:0]   fetch_index2;

	assign fetch_index1 = fetch_pc1[index_bits+1:2];
	assign fetch_index2 = fetch_pc2[index_bits+1:2];

	// reads see state before this cycle's writes
	assign fetch_hist1 = hist_mem[fetch_index1];
	assign fetch_hist2 = hist_mem[fetch_index2];
	assign hist_rd1    = hist_mem[hist_rd_index1];
	assign hist_rd2    = hist_mem[hist_rd_index2];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < entries; i++) begin
				hist_mem[i] <= '0;
			end
		end else begin
			if (hist_wr_en1)
				hist_mem[hist_wr_index1] <= hist_wr_data1;
			if (hist_wr_en2)
				hist_mem[hist_wr_index2] <= hist_wr_data2; // last write wins
		end
	end

endmodule

/* hw/resolve_update_unit.sv */
`timescale 1ns/1ps

module resolve_update_unit #(
	parameter int index_bits   = 4,
	parameter int history_bits = 3
) (
	input  logic [bp_pkg::PC_WIDTH-1:0] branch_pc1,
	input  logic                        branch_result1,
	input  logic                        branch_valid1,
	input  logic [bp_pkg::PC_WIDTH-1:0] branch_pc2,
	input  logic                        branch_result2,
	input  logic                        branch_valid2,
	input  logic [history_bits-1:0]     hist_rd1,
	input  logic [history_bits-1:0]     hist_rd2,
	output logic [index_bits-1:0]       hist_rd_index1,
	output logic [index_bits-1:0]       hist_rd_index2,
	output logic                        hist_wr_en1,
	output logic                        hist_wr_en2,
	output logic [index_bits-1:0]       hist_wr_index1,
	output logic [index_bits-1:0]       hist_wr_index2,
	output logic [history_bits-1:0]     hist_wr_data1,
	output logic [history_bits-1:0]     hist_wr_data2,
	output logic                        cnt_upd_en1,
	output logic                        cnt_upd_en2,
	output logic [history_bits-1:0]     cnt_upd_index1,
	output logic [history_bits-1:0]     cnt_upd_index2,
	output logic                        cnt_upd_taken1,
	output logic                        cnt_upd_taken2
);

	logic                    same_entry;
	logic [history_bits-1:0] new_hist1;
	logic [history_bits-1:0] base_hist2; // history port 2 builds on
	logic [history_bits-1:0] new_hist2;

	// oldest outcome drops off the top, newest enters at bit 0
	function automatic logic [history_bits-1:0] shift_in(
		input logic [history_bits-1:0] hist,
		input logic                    outcome
	);
		logic [history_bits:0] wide;
		wide = {hist, outcome};
		return wide[history_bits-1:0];
	endfunction

	// ==================================================
	// index extraction
	// ==================================================
	assign hist_rd_index1 = branch_pc1[index_bits+1:2]; // skip word offset
	assign hist_rd_index2 = branch_pc2[index_bits+1:2];

	assign same_entry = branch_valid1 && branch_valid2 &&
		(hist_rd_index1 == hist_rd_index2);

	// ==================================================
	// history chaining
	// ==================================================
	assign new_hist1  = shift_in(hist_rd1, branch_result1);
	assign base_hist2 = same_entry ? new_hist1 : hist_rd2; // port 1 applies first
	assign new_hist2  = shift_in(base_hist2, branch_result2);

	// port 2 write carries both outcomes when chained
	assign hist_wr_en1    = branch_valid1 && !same_entry;
	assign hist_wr_en2    = branch_valid2;
	assign hist_wr_index1 = hist_rd_index1;
	assign hist_wr_index2 = hist_rd_index2;
	assign hist_wr_data1  = new_hist1;
	assign hist_wr_data2  = new_hist2;

	// counter updates indexed by the history each port saw
	assign cnt_upd_en1    = branch_valid1;
	assign cnt_upd_en2    = branch_valid2;
	assign cnt_upd_index1 = hist_rd1;
	assign cnt_upd_index2 = base_hist2;
	assign cnt_upd_taken1 = branch_result1;
	assign cnt_upd_taken2 = branch_result2;

endmodule

/* hw/bp_pkg.sv */
package bp_pkg;

	// width of every pc port
	localparam int PC_WIDTH = 64;

	// ==================================================
	// two-bit saturating counter
	// ==================================================
	// upper two states predict taken, outer two are strong
	typedef enum logic [1:0] {
		strong_not_taken = 2'b00,
		weak_not_taken   = 2'b01,
		weak_taken       = 2'b10,
		strong_taken     = 2'b11
	} counter_state_t;

endpackage
